// File: design/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

	// Opcodes live in insn[31:29].
	typedef enum logic [2:0] {
		OP_MOVI = 3'd0,
		OP_LDR  = 3'd1,
		OP_STR  = 3'd2,
		OP_LDM  = 3'd3,
		OP_STM  = 3'd4
	} op_e;

	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_ACCESS  = 3'd1, // Request on the bus.
		S_WAIT    = 3'd2, // Load result to the register file.
		S_BASE_WB = 3'd3,
		S_DONE    = 3'd4
	} seq_state_e;

	typedef logic [31:0] insn_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;

	localparam int OP_LSB = 29;
	localparam int OP_W   = 3;

	// Flag bits.
	localparam int PRE_BIT  = 24;
	localparam int UP_BIT   = 23;
	localparam int BYTE_BIT = 22;
	localparam int WB_BIT   = 21;

	localparam int REG_W  = 4;
	localparam int RN_LSB = 16;
	localparam int RD_LSB = 12;

	// LDR/STR immediate offset.
	localparam int OFFSET_W = 12;

	// LDM/STM register list.
	localparam int LIST_W = 16;

	// MOVI puts Rd where the other ops keep Rn.
	localparam int MOVI_RD_LSB = 16;
	localparam int IMM_W       = 16;

	localparam int NUM_REGS = 16;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import mem_stage_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rd_a_num,
	input  reg_idx_t rd_b_num,
	input  reg_idx_t st_num,
	output word_t    rd_a_data,
	output word_t    rd_b_data,
	output word_t    st_data,
	input  logic     wr_en,
	input  reg_idx_t wr_num,
	input  word_t    wr_data
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_num] <= wr_data;
		end
	end

	// Reads see the old value during a write.
	assign rd_a_data = regs[rd_a_num];
	assign rd_b_data = regs[rd_b_num];
	assign st_data   = regs[st_num];

endmodule

`default_nettype wire

// File: design/issue_port.sv
`timescale 1ns/1ps
`default_nettype none

module issue_port
	import mem_stage_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  insn_t               insn,
	output logic                ack,
	output reg_idx_t            rd_a_num,
	output reg_idx_t            rd_b_num,
	input  word_t               rd_a_data,
	input  word_t               rd_b_data,
	output logic                start,
	output op_e                 op,
	output logic                pre,
	output logic                up,
	output logic                byte_sel,
	output logic                wback,
	output reg_idx_t            rn,
	output reg_idx_t            rd,
	output logic [OFFSET_W-1:0] offset,
	output logic [LIST_W-1:0]   reg_list,
	output word_t               base_val,
	output word_t               store_val,
	input  logic                done
);

	typedef enum logic [1:0] {IP_IDLE, IP_BUSY, IP_ACKED} ip_state_e;

	ip_state_e state;
	op_e       insn_op;
	logic      insn_movi;

	assign insn_op   = op_e'(insn[OP_LSB +: OP_W]);
	assign insn_movi = (insn_op == OP_MOVI);

	// Operands read straight from the held instruction.
	assign rd_a_num = insn[RN_LSB +: REG_W];
	assign rd_b_num = insn[RD_LSB +: REG_W];

	// Four-phase handshake with one start per req.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IP_IDLE;
			start <= 1'b0;
			ack   <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				IP_IDLE: if (req) begin
					start <= 1'b1;
					state <= IP_BUSY;
				end
				IP_BUSY: if (done) begin
					ack   <= 1'b1;
					state <= IP_ACKED;
				end
				IP_ACKED: if (!req) begin
					ack   <= 1'b0;
					state <= IP_IDLE;
				end
				default: state <= IP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IP_IDLE && req) begin
			op        <= insn_op;
			pre       <= insn[PRE_BIT];
			up        <= insn[UP_BIT];
			byte_sel  <= insn[BYTE_BIT];
			wback     <= insn[WB_BIT];
			rn        <= insn[RN_LSB +: REG_W];
			rd        <= insn_movi ? insn[MOVI_RD_LSB +: REG_W] : insn[RD_LSB +: REG_W];
			offset    <= insn[OFFSET_W-1:0];
			reg_list  <= insn[LIST_W-1:0];
			base_val  <= rd_a_data;
			store_val <= insn_movi ? {{(32-IMM_W){1'b0}}, insn[IMM_W-1:0]} : rd_b_data;
		end
	end

	assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
		else $error("ack rose while req was low");

endmodule

`default_nettype wire

// File: design/mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer
	import mem_stage_pkg::*;
#(
	parameter int ADDR_BITS = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  op_e                  op,
	input  logic                 pre,
	input  logic                 up,
	input  logic                 byte_sel,
	input  logic                 wback,
	input  reg_idx_t             rn,
	input  reg_idx_t             rd,
	input  logic [OFFSET_W-1:0]  offset,
	input  logic [LIST_W-1:0]    reg_list,
	input  word_t                base_val,
	input  word_t                store_val,
	output logic                 done,
	output logic [ADDR_BITS-1:0] bus_addr,
	output logic                 rd_req,
	output logic                 wr_req,
	output logic [3:0]           byte_en,
	output word_t                wr_data,
	input  word_t                rd_data,
	input  logic                 rw_wait,
	output reg_idx_t             st_num,
	input  word_t                st_data,
	output logic                 wr_en,
	output reg_idx_t             wr_num,
	output word_t                wr_data_rf
);

	seq_state_e        state;
	op_e               op_q;
	logic              byte_q, wback_q;
	reg_idx_t          rd_q, rn_q, ld_num;
	logic [LIST_W-1:0] list_q, list_next;
	logic [6:0]        run_off; // Byte offset into a block.
	word_t             addr_base, base_new, val_q, ld_data;

	logic     start_block, is_block, is_load, byte_mode;
	logic     [4:0] list_cnt;
	word_t    blk_span, blk_start, blk_new, ea;
	word_t    acc_addr, rot_h, rot_b, ld_val;
	reg_idx_t cur_reg;

	function automatic reg_idx_t lowest_set(input logic [LIST_W-1:0] list);
		reg_idx_t idx;
		idx = '0;
		for (int i = LIST_W - 1; i >= 0; i--) begin
			if (list[i]) idx = reg_idx_t'(i);
		end
		return idx;
	endfunction

	always_comb begin
		list_cnt = '0;
		for (int i = 0; i < LIST_W; i++) begin
			list_cnt = list_cnt + 5'(reg_list[i]);
		end
	end

	// Start-time address arithmetic.
	assign start_block = (op == OP_LDM) || (op == OP_STM);
	assign blk_span    = {25'b0, list_cnt, 2'b0};
	assign blk_start   = (up ? base_val : base_val - blk_span) + ((pre == up) ? 32'd4 : 32'd0);
	assign blk_new     = up ? base_val + blk_span : base_val - blk_span;
	assign ea          = up ? base_val + {20'b0, offset} : base_val - {20'b0, offset};

	assign is_block  = (op_q == OP_LDM) || (op_q == OP_STM);
	assign is_load   = (op_q == OP_LDR) || (op_q == OP_LDM);
	assign byte_mode = byte_q && !is_block;
	assign cur_reg   = is_block ? lowest_set(list_q) : rd_q;
	assign list_next = list_q & (list_q - 1'b1);
	assign acc_addr  = addr_base + {25'b0, run_off};

	// Bus side.
	assign bus_addr = acc_addr[ADDR_BITS+1:2];
	assign rd_req   = (state == S_ACCESS) && is_load;
	assign wr_req   = (state == S_ACCESS) && !is_load;
	assign byte_en  = byte_mode ? (4'b0001 << acc_addr[1:0]) : 4'hf;
	assign st_num   = cur_reg;
	assign wr_data  = byte_mode ? {4{val_q[7:0]}} : (is_block ? st_data : val_q);

	// Rotate addressed byte down to lane 0.
	assign rot_h  = acc_addr[1] ? {rd_data[15:0], rd_data[31:16]} : rd_data;
	assign rot_b  = acc_addr[0] ? {rot_h[7:0], rot_h[31:8]} : rot_h;
	assign ld_val = byte_mode ? {24'b0, rot_b[7:0]} : rot_b;

	always_comb begin
		wr_en      = 1'b0;
		wr_num     = rd_q;
		wr_data_rf = val_q;
		case (state)
			S_WAIT: begin
				wr_en      = is_load;
				wr_num     = ld_num;
				wr_data_rf = ld_data;
			end
			S_BASE_WB: begin
				wr_en      = 1'b1;
				wr_num     = rn_q;
				wr_data_rf = base_new;
			end
			S_DONE: wr_en = (op_q == OP_MOVI); // MOVI immediate.
			default: ;
		endcase
	end

	assign done = (state == S_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					if (op == OP_LDR || op == OP_STR) state <= S_ACCESS;
					else if (start_block && reg_list != '0) state <= S_ACCESS;
					else if (start_block && wback) state <= S_BASE_WB;
					else state <= S_DONE;
				end
				S_ACCESS: if (!rw_wait) begin
					if (is_load || list_next != '0) state <= S_WAIT;
					else if (wback_q) state <= S_BASE_WB;
					else state <= S_DONE;
				end
				S_WAIT: begin
					if (list_q != '0) state <= S_ACCESS;
					else if (wback_q) state <= S_BASE_WB;
					else state <= S_DONE;
				end
				S_BASE_WB: state <= S_DONE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start && state == S_IDLE) begin
			op_q    <= op;
			byte_q  <= byte_sel;
			wback_q <= wback;
			rd_q    <= rd;
			rn_q    <= rn;
			val_q   <= store_val;
			run_off <= '0;
			if (start_block) begin
				list_q    <= reg_list;
				addr_base <= blk_start;
				base_new  <= blk_new;
			end else begin
				list_q    <= '0;
				addr_base <= pre ? ea : base_val;
				base_new  <= ea;
			end
		end else if (state == S_ACCESS && !rw_wait) begin
			list_q  <= list_next;
			run_off <= run_off + 7'd4;
			ld_num  <= cur_reg;
			ld_data <= ld_val;
		end
	end

	// Request and address held through back-pressure.
	assert property (@(posedge clk) disable iff (rst)
		(rd_req || wr_req) && rw_wait |=> (rd_req || wr_req) && $stable(bus_addr))
		else $error("bus request changed during rw_wait");

endmodule

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
	import mem_stage_pkg::*;
#(
	parameter int ADDR_BITS   = 8,
	parameter int WAIT_CYCLES = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [ADDR_BITS-1:0] bus_addr,
	input  logic                 rd_req,
	input  logic                 wr_req,
	input  logic [3:0]           byte_en,
	input  word_t                wr_data,
	output word_t                rd_data,
	output logic                 rw_wait
);

	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

	word_t            mem [2**ADDR_BITS];
	logic [CNT_W-1:0] elapsed;
	logic             req_any;

	assign req_any = rd_req | wr_req;
	assign rw_wait = req_any && (int'(elapsed) < WAIT_CYCLES);

	// Counter restarts after every completed request.
	always_ff @(posedge clk) begin
		if (rst) begin
			elapsed <= '0;
		end else if (rw_wait) begin
			elapsed <= elapsed + 1'b1;
		end else begin
			elapsed <= '0;
		end
	end

	// Writes commit in the cycle rw_wait drops.
	always_ff @(posedge clk) begin
		if (wr_req && !rw_wait) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i]) mem[bus_addr][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
	end

	assign rd_data = mem[bus_addr];

	assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
		else $error("rd_req and wr_req high together");

endmodule

`default_nettype wire

// File: design/mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top
	import mem_stage_pkg::*;
#(
	parameter int ADDR_BITS   = 8,
	parameter int WAIT_CYCLES = 2
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     req,
	input  insn_t    insn,
	output logic     ack,
	output logic     wb_valid,
	output reg_idx_t wb_num,
	output word_t    wb_data
);

	reg_idx_t rf_a_num, rf_b_num, st_num, rn, rd;
	word_t    rf_a_data, rf_b_data, st_data, base_val, store_val;
	word_t    bus_wr_data, bus_rd_data;
	op_e      op;
	logic     start, done, pre, up, byte_sel, wback;
	logic     rd_req, wr_req, rw_wait;
	logic     [OFFSET_W-1:0] offset;
	logic     [LIST_W-1:0] reg_list;
	logic     [ADDR_BITS-1:0] bus_addr;
	logic     [3:0] byte_en;

	issue_port u_issue_port (
		.clk(clk), .rst(rst), .req(req), .insn(insn), .ack(ack),
		.rd_a_num(rf_a_num), .rd_b_num(rf_b_num),
		.rd_a_data(rf_a_data), .rd_b_data(rf_b_data),
		.start(start), .op(op), .pre(pre), .up(up), .byte_sel(byte_sel), .wback(wback),
		.rn(rn), .rd(rd), .offset(offset), .reg_list(reg_list),
		.base_val(base_val), .store_val(store_val), .done(done)
	);

	// The write port doubles as the writeback report.
	mem_sequencer #(.ADDR_BITS(ADDR_BITS)) u_mem_sequencer (
		.clk(clk), .rst(rst), .start(start), .op(op), .pre(pre), .up(up),
		.byte_sel(byte_sel), .wback(wback), .rn(rn), .rd(rd), .offset(offset),
		.reg_list(reg_list), .base_val(base_val), .store_val(store_val), .done(done),
		.bus_addr(bus_addr), .rd_req(rd_req), .wr_req(wr_req), .byte_en(byte_en),
		.wr_data(bus_wr_data), .rd_data(bus_rd_data), .rw_wait(rw_wait),
		.st_num(st_num), .st_data(st_data),
		.wr_en(wb_valid), .wr_num(wb_num), .wr_data_rf(wb_data)
	);

	reg_file u_reg_file (
		.clk(clk), .rst(rst),
		.rd_a_num(rf_a_num), .rd_b_num(rf_b_num), .st_num(st_num),
		.rd_a_data(rf_a_data), .rd_b_data(rf_b_data), .st_data(st_data),
		.wr_en(wb_valid), .wr_num(wb_num), .wr_data(wb_data)
	);

	data_ram #(.ADDR_BITS(ADDR_BITS), .WAIT_CYCLES(WAIT_CYCLES)) u_data_ram (
		.clk(clk), .rst(rst), .bus_addr(bus_addr), .rd_req(rd_req), .wr_req(wr_req),
		.byte_en(byte_en), .wr_data(bus_wr_data), .rd_data(bus_rd_data), .rw_wait(rw_wait)
	);

endmodule

`default_nettype wire

// File: verif/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each entry holds a test name, an instruction word and the writebacks expected before ack.
// Data values are random MOVI immediates drawn after the seed is set.
task automatic build_table();
	logic [15:0] list;
	word_t       base;
	logic        pre, up;
	string       mode;
	// Word transfers around r1 = 0x100.
	add_vec("movi base r1", movi_insn(4'd1, 16'h0100), 1);
	add_vec("movi data r2", movi_insn(4'd2, rand_imm()), 1);
	add_vec("movi data r3", movi_insn(4'd3, rand_imm()), 1);
	add_vec("str word pre up", xfer_insn(OP_STR, 1, 1, 0, 0, 4'd1, 4'd2, 12'd8), 0);
	add_vec("ldr word pre up", xfer_insn(OP_LDR, 1, 1, 0, 0, 4'd1, 4'd4, 12'd8), 1);
	add_vec("str word post down", xfer_insn(OP_STR, 0, 0, 0, 0, 4'd1, 4'd3, 12'd4), 0);
	add_vec("ldr word post down", xfer_insn(OP_LDR, 0, 0, 0, 0, 4'd1, 4'd5, 12'd12), 1);
	add_vec("str word pre down", xfer_insn(OP_STR, 1, 0, 0, 0, 4'd1, 4'd2, 12'd16), 0);
	add_vec("ldr word pre down", xfer_insn(OP_LDR, 1, 0, 0, 0, 4'd1, 4'd6, 12'd16), 1);
	add_vec("ldr word post up", xfer_insn(OP_LDR, 0, 1, 0, 0, 4'd1, 4'd9, 12'd8), 1);

	// One word at 0x200, then a byte into each lane.
	add_vec("movi base r8", movi_insn(4'd8, 16'h0200), 1);
	add_vec("str word for lanes", xfer_insn(OP_STR, 1, 1, 0, 0, 4'd8, 4'd3, 12'd0), 0);
	for (int lane = 0; lane < 4; lane++) begin
		add_vec($sformatf("movi byte r7 lane %0d", lane), movi_insn(4'd7, rand_imm()), 1);
		add_vec($sformatf("strb lane %0d", lane),
			xfer_insn(OP_STR, 1, 1, 1, 0, 4'd8, 4'd7, 12'(lane)), 0);
		add_vec($sformatf("ldr word after lane %0d", lane),
			xfer_insn(OP_LDR, 1, 1, 0, 0, 4'd8, 4'd9, 12'd0), 1);
		add_vec($sformatf("ldrb lane %0d", lane),
			xfer_insn(OP_LDR, 1, 1, 1, 0, 4'd8, 4'd10, 12'(lane)), 1);
	end

	// Base writeback comes after the data write.
	add_vec("ldr pre up wback", xfer_insn(OP_LDR, 1, 1, 0, 1, 4'd1, 4'd11, 12'd8), 2);
	add_vec("str post up wback", xfer_insn(OP_STR, 0, 1, 0, 1, 4'd1, 4'd2, 12'd16), 1);
	add_vec("ldr pre down wback", xfer_insn(OP_LDR, 1, 0, 0, 1, 4'd1, 4'd12, 12'd16), 2);
	add_vec("strb post up wback", xfer_insn(OP_STR, 0, 1, 1, 1, 4'd8, 4'd7, 12'd1), 1);
	add_vec("ldrb pre down wback", xfer_insn(OP_LDR, 1, 0, 1, 1, 4'd8, 4'd13, 12'd1), 2);

	// Block store, clear, block load. r0 is the base.
	for (int m = 0; m < 4; m++) begin
		pre  = m[0];
		up   = m[1];
		base = 32'h240 + 32'h60 * m;
		list = (rand_imm() & 16'hfffe) | 16'h0002;
		mode = $sformatf("%s %s", up ? "up" : "down", pre ? "pre" : "post");
		add_vec({"movi block base ", mode}, movi_insn(4'd0, base[15:0]), 1);
		for (int r = 1; r < NUM_REGS; r++) begin
			if (list[r]) add_vec($sformatf("movi block r%0d", r), movi_insn(4'(r), rand_imm()), 1);
		end
		add_vec({"stm ", mode}, block_insn(OP_STM, pre, up, 1, 4'd0, list), 1);
		for (int r = 1; r < NUM_REGS; r++) begin
			if (list[r]) add_vec($sformatf("movi clear r%0d", r), movi_insn(4'(r), 16'h0), 1);
		end
		add_vec({"movi block base again ", mode}, movi_insn(4'd0, base[15:0]), 1);
		add_vec({"ldm ", mode}, block_insn(OP_LDM, pre, up, 1, 4'd0, list), $countones(list) + 1);
	end

	// Base in the load list loses to the base write.
	add_vec("movi base r0", movi_insn(4'd0, 16'h0180), 1);
	add_vec("stm post up no wback", block_insn(OP_STM, 0, 1, 0, 4'd0, 16'h000c), 0);
	add_vec("ldm base in list", block_insn(OP_LDM, 0, 1, 1, 4'd0, 16'h0021), 3);
endtask

`endif

// File: verif/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
	import mem_stage_pkg::*;
();

	localparam int ADDR_BITS   = 8;
	localparam int WAIT_CYCLES = 2;

	logic     clk, rst, req, ack, wb_valid;
	insn_t    insn;
	reg_idx_t wb_num;
	word_t    wb_data;

	string    t_name[$];
	insn_t    t_insn[$];
	int       t_nwb[$];
	word_t    mdl_regs [NUM_REGS];
	word_t    mdl_mem [2**ADDR_BITS];
	reg_idx_t exp_num[$];
	word_t    exp_data[$];

	int   errors = 0;
	int   passed = 0;
	int   failed = 0;
	int   wb_seen = 0;
	int   ack_rises = 0;
	int   cycles = 0;
	int   cycle_limit = 0;
	logic in_flight = 1'b0;
	logic ack_q = 1'b0;

	mem_stage_top #(.ADDR_BITS(ADDR_BITS), .WAIT_CYCLES(WAIT_CYCLES)) u_mem_stage_top (
		.clk(clk), .rst(rst), .req(req), .insn(insn), .ack(ack),
		.wb_valid(wb_valid), .wb_num(wb_num), .wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic insn_t movi_insn(input reg_idx_t rd, input logic [15:0] imm);
		insn_t w;
		w = '0;
		w[OP_LSB +: OP_W]       = OP_MOVI;
		w[MOVI_RD_LSB +: REG_W] = rd;
		w[IMM_W-1:0]            = imm;
		return w;
	endfunction

	function automatic insn_t xfer_insn(input op_e op, input bit pre, input bit up,
			input bit bsel, input bit wb, input reg_idx_t rn, input reg_idx_t rd,
			input logic [11:0] off);
		insn_t w;
		w = '0;
		w[OP_LSB +: OP_W] = op;
		w[PRE_BIT]        = pre;
		w[UP_BIT]         = up;
		w[BYTE_BIT]       = bsel;
		w[WB_BIT]         = wb;
		w[RN_LSB +: REG_W] = rn;
		w[RD_LSB +: REG_W] = rd;
		w[OFFSET_W-1:0]   = off;
		return w;
	endfunction

	function automatic insn_t block_insn(input op_e op, input bit pre, input bit up,
			input bit wb, input reg_idx_t rn, input logic [15:0] list);
		insn_t w;
		w = xfer_insn(op, pre, up, 0, wb, rn, 4'd0, 12'd0);
		w[LIST_W-1:0] = list;
		return w;
	endfunction

	function automatic logic [15:0] rand_imm();
		return 16'($urandom);
	endfunction

	function automatic logic [ADDR_BITS-1:0] word_index(input word_t addr);
		return addr[ADDR_BITS+1:2];
	endfunction

	task automatic add_vec(input string name, input insn_t ins, input int nwb);
		t_name.push_back(name);
		t_insn.push_back(ins);
		t_nwb.push_back(nwb);
	endtask

	`include "tb_vectors.svh"

	// Queue a predicted write and apply it to the model.
	task automatic expect_write(input reg_idx_t num, input word_t data);
		exp_num.push_back(num);
		exp_data.push_back(data);
		mdl_regs[num] = data;
	endtask

	task automatic predict(input insn_t ins);
		op_e         op;
		logic        pre, up, bsel, wb;
		reg_idx_t    rn, rd;
		logic [15:0] list;
		word_t       base, off, ea, addr, data;
		int          n;
		op   = op_e'(ins[OP_LSB +: OP_W]);
		pre  = ins[PRE_BIT];
		up   = ins[UP_BIT];
		bsel = ins[BYTE_BIT];
		wb   = ins[WB_BIT];
		rn   = ins[RN_LSB +: REG_W];
		rd   = ins[RD_LSB +: REG_W];
		list = ins[LIST_W-1:0];
		off  = {20'b0, ins[OFFSET_W-1:0]};
		base = mdl_regs[rn];
		case (op)
			OP_MOVI: expect_write(ins[MOVI_RD_LSB +: REG_W], {16'b0, ins[IMM_W-1:0]});
			OP_LDR, OP_STR: begin
				ea   = up ? base + off : base - off;
				addr = pre ? ea : base;
				if (op == OP_STR && bsel) begin
					mdl_mem[word_index(addr)][8*addr[1:0] +: 8] = mdl_regs[rd][7:0];
				end else if (op == OP_STR) begin
					mdl_mem[word_index(addr)] = mdl_regs[rd];
				end else begin
					data = mdl_mem[word_index(addr)];
					expect_write(rd, bsel ? {24'b0, data[8*addr[1:0] +: 8]} : data);
				end
				if (wb) expect_write(rn, ea);
			end
			default: begin
				n = $countones(list);
				if (up) addr = pre ? base + 4 : base; // Lowest address of the block.
				else addr = pre ? base - 4*n : base - 4*n + 4;
				for (int k = 0; k < NUM_REGS; k++) begin
					if (list[k]) begin
						if (op == OP_STM) mdl_mem[word_index(addr)] = mdl_regs[k];
						else expect_write(reg_idx_t'(k), mdl_mem[word_index(addr)]);
						addr = addr + 4;
					end
				end
				if (wb) expect_write(rn, up ? base + 4*n : base - 4*n);
			end
		endcase
	endtask

	task automatic check_write(input reg_idx_t num, input word_t data);
		if (wb_num !== num) begin
			$display("ERROR %0t wb_num expected %0d got %0d", $time, num, wb_num);
			errors++;
		end
		if (wb_data !== data) begin
			$display("ERROR %0t wb_data expected %h got %h", $time, data, wb_data);
			errors++;
		end
	endtask

	// Writeback and ack monitor sampling mid-cycle.
	always @(negedge clk) begin
		if (!rst && ack && !ack_q) begin
			ack_rises++;
			in_flight = 1'b0;
		end
		ack_q = ack;
		if (!rst && wb_valid) begin
			wb_seen++;
			if (!in_flight) begin
				$display("Writeback to r%0d at %0t arrived after ack", wb_num, $time);
				errors++;
			end else if (exp_num.size() == 0) begin
				$display("Unexpected writeback to r%0d at %0t", wb_num, $time);
				errors++;
			end else begin
				check_write(exp_num.pop_front(), exp_data.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic run_test(input int idx);
		int err_before;
		err_before = errors;
		wb_seen    = 0;
		ack_rises  = 0;
		predict(t_insn[idx]);
		@(posedge clk);
		#1;
		insn      = t_insn[idx];
		req       = 1'b1;
		in_flight = 1'b1;
		@(negedge clk);
		while (!ack) @(negedge clk);
		@(posedge clk);
		#1;
		req = 1'b0;
		@(negedge clk);
		while (ack) @(negedge clk);
		@(posedge clk);
		if (wb_seen != t_nwb[idx]) begin
			$display("%s saw %0d writebacks, expected %0d", t_name[idx], wb_seen, t_nwb[idx]);
			errors++;
		end
		if (exp_num.size() != 0) begin
			$display("%s is missing %0d writebacks", t_name[idx], exp_num.size());
			errors++;
			exp_num.delete();
			exp_data.delete();
		end
		if (ack_rises != 1) begin
			$display("%s got %0d acks for one req", t_name[idx], ack_rises);
			errors++;
		end
		if (errors == err_before) passed++;
		else failed++;
		$display("[%0d] %s: %s", idx, t_name[idx], (errors == err_before) ? "ok" : "FAILED");
	endtask

	initial begin
		rst  = 1'b1;
		req  = 1'b0;
		insn = '0;
		void'($urandom(32'hd734));
		for (int i = 0; i < NUM_REGS; i++) mdl_regs[i] = '0;
		for (int i = 0; i < 2**ADDR_BITS; i++) mdl_mem[i] = '0;
		build_table();
		cycle_limit = t_insn.size() * (NUM_REGS * (WAIT_CYCLES + 1) + 8) + 8;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < t_insn.size(); i++) begin
			run_test(i);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			t_insn.size(), passed, failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verif
design/mem_stage_pkg.sv
design/reg_file.sv
design/issue_port.sv
design/mem_sequencer.sv
design/data_ram.sv
design/mem_stage_top.sv
verif/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - design/mem_stage_pkg.sv
      - design/reg_file.sv
      - design/issue_port.sv
      - design/mem_sequencer.sv
      - design/data_ram.sv
      - design/mem_stage_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_mem_stage.sv
